// ==== common/sdram_pkg.sv ====
package sdram_pkg;

    // SDRAM bus widths
    localparam int ADDR_BITS = 13;
    localparam int BANK_BITS = 2;
    localparam int DQ_BITS   = 16;
    localparam int DQM_BITS  = 2;

    // Derived bank count and byte lane width
    localparam int BANKS     = 1 << BANK_BITS;
    localparam int BYTE_BITS = DQ_BITS / DQM_BITS;

    // A10 on PRECHARGE closes every bank
    localparam int AP_BIT = 10;

    // LOAD_MODE address fields
    // Burst length in [2:0], CAS latency in [6:4]
    localparam int MODE_BL_LSB = 0;
    localparam int MODE_CL_LSB = 4;

    // Burst length codes of the mode register
    localparam logic [2:0] BL_CODE_1 = 3'd0;
    localparam logic [2:0] BL_CODE_2 = 3'd1;
    localparam logic [2:0] BL_CODE_4 = 3'd2;
    localparam logic [2:0] BL_CODE_8 = 3'd3;

    // Refreshes issued during power-up
    localparam int INIT_REFRESHES = 2;

    // NOP cycles that follow each command
    localparam int T_RP  = 2;
    localparam int T_RCD = 2;
    localparam int T_RFC = 4;
    localparam int T_MRD = 2;

    // Command nibble {cs, ras, cas, we}
    // All four strobes are active low
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1111
    } cmd_t;

endpackage

// ==== sdram_ctrl/sdram_ctrl.sv ====
`timescale 1ns/1ps

module sdram_ctrl import sdram_pkg::*; #(
    parameter int ROW_BITS         = 13,
    parameter int COL_BITS         = 9,
    parameter int CAS_LAT          = 3,
    parameter int REFRESH_INTERVAL = 781,
    parameter int INIT_CYCLES      = 20000
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // User side
    input  logic                                   req,
    input  logic                                   wr,
    input  logic [BANK_BITS+ROW_BITS+COL_BITS-1:0] addr,
    input  logic [DQ_BITS-1:0]                     wdata,
    input  logic [DQM_BITS-1:0]                    wmask,
    output logic                                   busy,
    output logic                                   done,
    output logic [DQ_BITS-1:0]                     rdata,
    output logic                                   rdata_valid,
    // SDRAM side
    output cmd_t                                   cmd,
    output logic [ADDR_BITS-1:0]                   sa,
    output logic [BANK_BITS-1:0]                   ba,
    output logic [DQM_BITS-1:0]                    dqm,
    output logic [DQ_BITS-1:0]                     dq_wr,
    output logic                                   dq_oe,
    input  logic [DQ_BITS-1:0]                     dq_rd
);

    // User address is {bank, row, col}
    localparam int UA_BITS = BANK_BITS + ROW_BITS + COL_BITS;

    // Delay counter must hold the power-up wait
    localparam int DLY_W = $clog2(INIT_CYCLES + 8);
    localparam int REF_W = $clog2(REFRESH_INTERVAL + 1);

    // Precharge-all address and the mode word (sequential, BL1)
    localparam logic [ADDR_BITS-1:0] PRE_ALL = ADDR_BITS'(1 << AP_BIT);
    localparam logic [ADDR_BITS-1:0] MODE_WORD =
        ADDR_BITS'((CAS_LAT << MODE_CL_LSB) | (int'(BL_CODE_1) << MODE_BL_LSB));

    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_INIT_REF,
        ST_INIT_MODE,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_WRITE,
        ST_READ,
        ST_PRECHARGE,
        ST_READ_WAIT,
        ST_FINISH,
        ST_WAIT
    } state_t;

    state_t             state;
    state_t             ret_state;
    logic [DLY_W-1:0]   delay;
    logic [1:0]         init_refs;
    logic [REF_W-1:0]   ref_cnt;
    logic               ref_tick;
    logic               ref_pending;
    logic               accept;
    logic               capture;

    // Latched request fields
    logic                 req_wr;
    logic [BANK_BITS-1:0] req_bank;
    logic [ROW_BITS-1:0]  req_row;
    logic [COL_BITS-1:0]  req_col;
    logic [DQ_BITS-1:0]   req_wdata;
    logic [DQM_BITS-1:0]  req_wmask;

    // busy is only low in ST_IDLE
    assign accept  = req && !busy;
    assign capture = (state == ST_READ_WAIT) && (delay == '0);

    // Free-running refresh timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_cnt <= REF_W'(REFRESH_INTERVAL - 1);
        end else if (ref_cnt == '0) begin
            ref_cnt <= REF_W'(REFRESH_INTERVAL - 1);
        end else begin
            ref_cnt <= ref_cnt - 1'b1;
        end
    end

    assign ref_tick = (ref_cnt == '0);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_wr    <= wr;
            req_bank  <= addr[UA_BITS-1 -: BANK_BITS];
            req_row   <= addr[COL_BITS +: ROW_BITS];
            req_col   <= addr[COL_BITS-1:0];
            req_wdata <= wdata;
            req_wmask <= wmask;
        end
        if (capture) begin
            rdata <= dq_rd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_INIT_WAIT;
            ret_state   <= ST_IDLE;
            delay       <= DLY_W'(INIT_CYCLES - 1);
            init_refs   <= '0;
            ref_pending <= 1'b0;
            busy        <= 1'b1;
            done        <= 1'b0;
            rdata_valid <= 1'b0;
            cmd         <= CMD_NOP;
            sa          <= '0;
            ba          <= '0;
            dqm         <= '1;
            dq_wr       <= '0;
            dq_oe       <= 1'b0;
        end else begin
            // One-cycle outputs
            cmd         <= CMD_NOP;
            dq_oe       <= 1'b0;
            done        <= 1'b0;
            rdata_valid <= 1'b0;

            case (state)
                ST_INIT_WAIT: begin
                    if (delay == '0) begin
                        cmd       <= CMD_PRECHARGE;
                        sa        <= PRE_ALL;
                        init_refs <= 2'(INIT_REFRESHES);
                        delay     <= DLY_W'(T_RP - 1);
                        ret_state <= ST_INIT_REF;
                        state     <= ST_WAIT;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                ST_INIT_REF: begin
                    cmd       <= CMD_REFRESH;
                    init_refs <= init_refs - 2'd1;
                    delay     <= DLY_W'(T_RFC - 1);
                    ret_state <= (init_refs == 2'd1) ? ST_INIT_MODE : ST_INIT_REF;
                    state     <= ST_WAIT;
                end
                ST_INIT_MODE: begin
                    cmd       <= CMD_LOAD_MODE;
                    sa        <= MODE_WORD;
                    delay     <= DLY_W'(T_MRD - 1);
                    ret_state <= ST_IDLE;
                    state     <= ST_WAIT;
                end
                ST_IDLE: begin
                    if (accept) begin
                        busy  <= 1'b1;
                        state <= ST_ACTIVATE;
                    end else if (ref_pending) begin
                        busy      <= 1'b1;
                        ret_state <= ST_IDLE;
                        state     <= ST_REFRESH;
                    end else begin
                        busy <= 1'b0;
                    end
                end
                ST_REFRESH: begin
                    cmd         <= CMD_REFRESH;
                    ref_pending <= 1'b0;
                    delay       <= DLY_W'(T_RFC - 1);
                    state       <= ST_WAIT;
                end
                ST_ACTIVATE: begin
                    // Refresh due at acceptance goes first
                    if (ref_pending) begin
                        ret_state <= ST_ACTIVATE;
                        state     <= ST_REFRESH;
                    end else begin
                        cmd       <= CMD_ACTIVE;
                        ba        <= req_bank;
                        sa        <= ADDR_BITS'(req_row);
                        delay     <= DLY_W'(T_RCD - 1);
                        ret_state <= req_wr ? ST_WRITE : ST_READ;
                        state     <= ST_WAIT;
                    end
                end
                ST_WRITE: begin
                    cmd   <= CMD_WRITE;
                    ba    <= req_bank;
                    sa    <= ADDR_BITS'(req_col);
                    dqm   <= ~req_wmask;
                    dq_wr <= req_wdata;
                    dq_oe <= 1'b1;
                    state <= ST_PRECHARGE;
                end
                ST_READ: begin
                    cmd   <= CMD_READ;
                    ba    <= req_bank;
                    sa    <= ADDR_BITS'(req_col);
                    dqm   <= '0;
                    state <= ST_PRECHARGE;
                end
                ST_PRECHARGE: begin
                    cmd <= CMD_PRECHARGE;
                    ba  <= req_bank;
                    sa  <= '0;
                    if (req_wr) begin
                        delay     <= DLY_W'(T_RP - 1);
                        ret_state <= ST_FINISH;
                        state     <= ST_WAIT;
                    end else begin
                        // Read word lands CAS_LAT cycles after READ
                        delay <= DLY_W'(CAS_LAT - 1);
                        state <= ST_READ_WAIT;
                    end
                end
                ST_READ_WAIT: begin
                    if (capture) begin
                        rdata_valid <= 1'b1;
                        done        <= 1'b1;
                        state       <= ST_IDLE;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                ST_FINISH: begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                ST_WAIT: begin
                    if (delay == '0) begin
                        state <= ret_state;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // Timer tick wins over the clear in ST_REFRESH
            if (ref_tick) begin
                ref_pending <= 1'b1;
            end
        end
    end

endmodule

// ==== sdram_model/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model import sdram_pkg::*; #(
    parameter int ROW_BITS = 13,
    parameter int COL_BITS = 9
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cmd_t                 cmd,
    input  logic [ADDR_BITS-1:0] sa,
    input  logic [BANK_BITS-1:0] ba,
    input  logic [DQM_BITS-1:0]  dqm,
    input  logic [DQ_BITS-1:0]   dq_wr,
    input  logic                 dq_oe,
    output logic [DQ_BITS-1:0]   dq_rd
);

    // Flat word address {bank, row, col}
    localparam int MEM_AW     = BANK_BITS + ROW_BITS + COL_BITS;
    localparam int PIPE_DEPTH = 3;

    logic [DQ_BITS-1:0]    mem [1 << MEM_AW];

    // Per-bank row state
    logic [BANKS-1:0]      bank_open;
    logic [ROW_BITS-1:0]   open_row [BANKS];

    // Mode register
    logic [2:0]            mode_bl;
    logic [2:0]            mode_cl;
    logic [3:0]            burst_len;

    // Burst engines
    logic [2:0]            rd_left;
    logic [2:0]            wr_left;
    logic [MEM_AW-1:0]     rd_next;
    logic [MEM_AW-1:0]     wr_next;
    logic                  rd_slot;
    logic [MEM_AW-1:0]     rd_addr;
    logic                  wr_slot;
    logic [MEM_AW-1:0]     wr_addr;
    logic                  wr_en;
    logic [MEM_AW-1:0]     cmd_addr;

    // Read address pipeline
    logic [PIPE_DEPTH-1:0] rp_valid;
    logic [MEM_AW-1:0]     rp_addr [PIPE_DEPTH];
    logic [1:0]            cl_idx;

    // Address of the command on the bus, row from the open row
    assign cmd_addr = {ba, open_row[ba], sa[COL_BITS-1:0]};

    always_comb begin
        case (mode_bl)
            BL_CODE_2: burst_len = 4'd2;
            BL_CODE_4: burst_len = 4'd4;
            BL_CODE_8: burst_len = 4'd8;
            default:   burst_len = 4'd1;
        endcase
    end

    // Word slot entering the read pipeline
    // A WRITE cuts a running read burst short
    always_comb begin
        rd_slot = 1'b0;
        rd_addr = rd_next;
        if (cmd == CMD_READ) begin
            rd_slot = bank_open[ba];
            rd_addr = cmd_addr;
        end else if (cmd != CMD_WRITE && rd_left != '0) begin
            rd_slot = 1'b1;
        end
    end

    // Same for writes, data only taken while dq_oe is high
    always_comb begin
        wr_slot = 1'b0;
        wr_addr = wr_next;
        if (cmd == CMD_WRITE) begin
            wr_slot = bank_open[ba];
            wr_addr = cmd_addr;
        end else if (cmd != CMD_READ && wr_left != '0) begin
            wr_slot = 1'b1;
        end
    end

    assign wr_en = wr_slot && dq_oe;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_open <= '0;
            mode_bl   <= BL_CODE_1;
            mode_cl   <= 3'd3;
            rd_left   <= '0;
            wr_left   <= '0;
            rp_valid  <= '0;
        end else begin
            rp_valid <= {rp_valid[PIPE_DEPTH-2:0], rd_slot};
            if (rd_left != '0) begin
                rd_left <= rd_left - 3'd1;
            end
            if (wr_left != '0) begin
                wr_left <= wr_left - 3'd1;
            end
            case (cmd)
                CMD_ACTIVE: begin
                    bank_open[ba] <= 1'b1;
                end
                CMD_PRECHARGE: begin
                    if (sa[AP_BIT]) begin
                        bank_open <= '0;
                    end else begin
                        bank_open[ba] <= 1'b0;
                    end
                end
                CMD_READ: begin
                    rd_left <= bank_open[ba] ? 3'(burst_len - 4'd1) : 3'd0;
                    wr_left <= '0;
                end
                CMD_WRITE: begin
                    wr_left <= bank_open[ba] ? 3'(burst_len - 4'd1) : 3'd0;
                    rd_left <= '0;
                end
                CMD_LOAD_MODE: begin
                    mode_bl <= sa[MODE_BL_LSB +: 3];
                    mode_cl <= sa[MODE_CL_LSB +: 3];
                end
                // Refresh only matters to real cells
                CMD_REFRESH, CMD_NOP, CMD_INHIBIT: begin
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd == CMD_ACTIVE) begin
            open_row[ba] <= sa[ROW_BITS-1:0];
        end
        // Next burst word, column wraps inside the row
        if (rd_slot) begin
            rd_next <= {rd_addr[MEM_AW-1:COL_BITS], rd_addr[COL_BITS-1:0] + 1'b1};
        end
        if (wr_slot) begin
            wr_next <= {wr_addr[MEM_AW-1:COL_BITS], wr_addr[COL_BITS-1:0] + 1'b1};
        end
        rp_addr[0] <= rd_addr;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            rp_addr[i] <= rp_addr[i-1];
        end
    end

    // dqm bit low writes that byte
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < DQM_BITS; b++) begin
                if (!dqm[b]) begin
                    mem[wr_addr][b*BYTE_BITS +: BYTE_BITS] <=
                        dq_wr[b*BYTE_BITS +: BYTE_BITS];
                end
            end
        end
    end

    // Stage 1 lines up with CL2, stage 2 with CL3
    assign cl_idx = (mode_cl == 3'd2) ? 2'd1 : 2'd2;
    assign dq_rd  = rp_valid[cl_idx] ? mem[rp_addr[cl_idx]] : '0;

endmodule

// ==== verilog/sdram_subsys.sv ====
`timescale 1ns/1ps

module sdram_subsys import sdram_pkg::*; #(
    parameter int ROW_BITS         = 6,
    parameter int COL_BITS         = 5,
    parameter int CAS_LAT          = 3,
    parameter int REFRESH_INTERVAL = 390,
    parameter int INIT_CYCLES      = 100
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req,
    input  logic                                   wr,
    input  logic [BANK_BITS+ROW_BITS+COL_BITS-1:0] addr,
    input  logic [DQ_BITS-1:0]                     wdata,
    input  logic [DQM_BITS-1:0]                    wmask,
    output logic                                   busy,
    output logic                                   done,
    output logic [DQ_BITS-1:0]                     rdata,
    output logic                                   rdata_valid
);

    // SDRAM bus, dq split into both directions
    cmd_t                 cmd;
    logic [ADDR_BITS-1:0] sa;
    logic [BANK_BITS-1:0] ba;
    logic [DQM_BITS-1:0]  dqm;
    logic [DQ_BITS-1:0]   dq_wr;
    logic [DQ_BITS-1:0]   dq_rd;
    logic                 dq_oe;

    sdram_ctrl #(
        .ROW_BITS         (ROW_BITS),
        .COL_BITS         (COL_BITS),
        .CAS_LAT          (CAS_LAT),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .INIT_CYCLES      (INIT_CYCLES)
    ) i_ctrl (.*);

    sdram_model #(
        .ROW_BITS (ROW_BITS),
        .COL_BITS (COL_BITS)
    ) i_model (.*);

endmodule

// ==== verification/tb_sdram_subsys.sv ====
`timescale 1ns/1ps

module tb_sdram_subsys import sdram_pkg::*; ();

    // Small array, fast refresh to force interleaving
    localparam int ROW_BITS         = 6;
    localparam int COL_BITS         = 5;
    localparam int CAS_LAT          = 2;
    localparam int REFRESH_INTERVAL = 40;
    localparam int INIT_CYCLES      = 100;
    localparam int UA_BITS          = BANK_BITS + ROW_BITS + COL_BITS;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int MAX_GAP        = 8;
    localparam int CYCLES_PER_VEC = 64;
    localparam int TAIL_CYCLES    = 20;
    // Vector that also gets a req strobe while busy
    localparam int STROBE_IDX     = 6;
    localparam string VEC_FILE    = "verification/sdram_vectors.txt";

    logic                 clk;
    logic                 rst_n;
    logic                 req;
    logic                 wr;
    logic [UA_BITS-1:0]   addr;
    logic [DQ_BITS-1:0]   wdata;
    logic [DQM_BITS-1:0]  wmask;
    logic                 busy;
    logic                 done;
    logic [DQ_BITS-1:0]   rdata;
    logic                 rdata_valid;

    // Parsed vectors
    logic [7:0]           vec_op [$];
    logic [UA_BITS-1:0]   vec_addr [$];
    logic [DQ_BITS-1:0]   vec_data [$];
    logic [DQM_BITS-1:0]  vec_mask [$];

    int errors       = 0;
    int checks       = 0;
    int n_reads      = 0;
    int accepted_cnt = 0;
    int done_cnt     = 0;
    int valid_cnt    = 0;
    bit vec_loaded   = 1'b0;

    sdram_subsys #(
        .ROW_BITS         (ROW_BITS),
        .COL_BITS         (COL_BITS),
        .CAS_LAT          (CAS_LAT),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .INIT_CYCLES      (INIT_CYCLES)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .wr          (wr),
        .addr        (addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .busy        (busy),
        .done        (done),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Lines starting with # are skipped
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the vector file %s", VEC_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, a, d, m);
                if (n == 4 && (op == "W" || op == "R")) begin
                    vec_op.push_back(op);
                    vec_addr.push_back(a[UA_BITS-1:0]);
                    vec_data.push_back(d[DQ_BITS-1:0]);
                    vec_mask.push_back(m[DQM_BITS-1:0]);
                    if (op == "R") n_reads++;
                end else begin
                    errors++;
                    $display("could not parse vector line: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // Busy must cover the whole power-up wait
    task automatic check_init();
        repeat (INIT_CYCLES) begin
            @(negedge clk);
            check("busy", busy, 1'b1);
        end
    endtask

    // One-cycle req while a request is in flight
    // The controller has to drop it
    task automatic strobe_while_busy();
        @(posedge clk);
        req <= 1'b1;
        @(negedge clk);
        check("busy", busy, 1'b1);
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic run_vector(input int idx);
        bit is_read;
        int gap;
        is_read = (vec_op[idx] == "R");
        gap = $urandom % MAX_GAP;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        req   <= 1'b1;
        wr    <= ~is_read;
        addr  <= vec_addr[idx];
        wdata <= is_read ? '0 : vec_data[idx];
        wmask <= vec_mask[idx];
        // Held until the controller sees it with busy low
        @(negedge clk);
        while (busy) @(negedge clk);
        accepted_cnt++;
        @(posedge clk);
        req <= 1'b0;
        if (idx == STROBE_IDX) strobe_while_busy();
        @(negedge clk);
        while (!done) @(negedge clk);
        check("rdata_valid", rdata_valid, is_read);
        if (is_read) check("rdata", rdata, vec_data[idx]);
    endtask

    // Every done pulse needs an accepted request
    always @(negedge clk) begin
        if (rst_n) begin
            if (done) begin
                if (done_cnt >= accepted_cnt) begin
                    errors++;
                    $display("done pulsed with no request outstanding at %0t", $time);
                end
                done_cnt++;
            end
            if (rdata_valid) begin
                valid_cnt++;
                check("done", done, 1'b1);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        wmask = '0;
        void'($urandom(32'hca2c));
        load_vectors();
        vec_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        check_init();
        for (int i = 0; i < vec_op.size(); i++) begin
            run_vector(i);
        end
        // Room for a stray done after the last request
        repeat (TAIL_CYCLES) @(negedge clk);
        check("done count", done_cnt, vec_op.size());
        check("rdata_valid count", valid_cnt, n_reads);
        if (vec_op.size() == 0) begin
            errors++;
            $display("no vectors were run");
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Budget scales with the vector count
    initial begin
        int budget;
        wait (vec_loaded);
        budget = RESET_CYCLES + INIT_CYCLES + TAIL_CYCLES + CYCLES_PER_VEC * vec_op.size();
        repeat (budget) @(posedge clk);
        errors++;
        $display("run timed out after %0d cycles at %0t", budget, $time);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verification/sdram_vectors.txt ====
# op addr data mask, all hex; addr is {bank, row, col}, mask bit set writes that byte
# R lines carry the expected read word in the data column, mask unused
W 0000 1234 3
R 0000 1234 0
W 0003 a5a5 3
R 0003 a5a5 0
W 0003 00ff 1
R 0003 a5ff 0
W 0003 3c00 2
R 0003 3cff 0
W 0803 1111 3
W 1003 2222 3
W 1803 3333 3
W 0023 4444 3
W 00a3 5555 3
R 0803 1111 0
R 1003 2222 0
R 1803 3333 0
R 0023 4444 0
R 00a3 5555 0
R 0003 3cff 0
W 07ff beef 3
W 1fff cafe 3
R 07ff beef 0
R 1fff cafe 0
W 1fff 0000 2
R 1fff 00fe 0
W 0000 ffff 1
R 0000 12ff 0
R 0803 1111 0
R 00a3 5555 0
W 0403 0f0f 3
R 0403 0f0f 0

// ==== project.f ====
common/sdram_pkg.sv
sdram_ctrl/sdram_ctrl.sv
sdram_model/sdram_model.sv
verilog/sdram_subsys.sv
verification/tb_sdram_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sdram_subsys
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: sim clean

# Build and run, pass only if the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
